// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= decode_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/decode_core_tb.sv
`timescale 1ns/1ns

module decode_core_tb;

  localparam int PROG_LEN     = 70;
  localparam int N_FIXED      = 30;
  localparam int MEM_DEPTH    = 128;
  localparam int WORST_SHIFT  = 32;
  localparam int DRAIN_CYCLES = WORST_SHIFT + 8;
  localparam int TIMEOUT_NS   = PROG_LEN * WORST_SHIFT * 4 + 1000;
  localparam logic [31:0] SEED = 32'd21;

  logic               clk           = 1'b0;
  logic               rst           = 1'b1;
  logic               fetch_valid_i = 1'b0;
  core_pkg::inst_t    fetch_inst_i  = '0;
  core_pkg::data_t    fetch_pc_i    = '0;
  logic               fetch_ready_o;
  logic               wb_valid_o;
  core_pkg::reg_idx_t wb_rd_o;
  core_pkg::data_t    wb_data_o;
  logic               redirect_valid_o;
  core_pkg::data_t    redirect_pc_o;

  core_pkg::inst_t    prog      [MEM_DEPTH];
  core_pkg::reg_idx_t exp_rd    [MEM_DEPTH];
  core_pkg::data_t    exp_data  [MEM_DEPTH];
  core_pkg::data_t    exp_redir [MEM_DEPTH];
  core_pkg::reg_idx_t exp_rd_now;
  core_pkg::data_t    exp_data_now;
  core_pkg::data_t    exp_redir_now;
  core_pkg::data_t    fpc       = '0;
  int                 n_wb      = 0;
  int                 n_redir   = 0;
  int                 wb_idx    = 0;
  int                 redir_idx = 0;
  int                 wb_err    = 0;
  int                 redir_err = 0;
  int                 proto_err = 0;

  decode_core uut (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_inst_i     (fetch_inst_i),
    .fetch_pc_i       (fetch_pc_i),
    .fetch_ready_o    (fetch_ready_o),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic core_pkg::inst_t enc_r(logic [6:0] f7, core_pkg::reg_idx_t rs2,
                                            core_pkg::reg_idx_t rs1, logic [2:0] f3,
                                            core_pkg::reg_idx_t rd);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, core_pkg::OP_REG};
  endfunction

  function automatic core_pkg::inst_t enc_i(logic [11:0] imm, core_pkg::reg_idx_t rs1,
                                            logic [2:0] f3, core_pkg::reg_idx_t rd,
                                            logic [6:0] opc);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
  endfunction

  function automatic core_pkg::inst_t enc_u(logic [19:0] imm, core_pkg::reg_idx_t rd,
                                            logic [6:0] opc);
    return {imm, 1'b0, rd, opc};
  endfunction

  function automatic core_pkg::inst_t enc_b(logic [12:0] off, core_pkg::reg_idx_t rs2,
                                            core_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11],
            core_pkg::OP_BRANCH};
  endfunction

  function automatic core_pkg::inst_t enc_j(logic [20:0] off, core_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, core_pkg::OP_JAL};
  endfunction

  function automatic core_pkg::data_t alu_ref(logic [2:0] f3, logic alt, core_pkg::data_t a,
                                              core_pkg::data_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, core_pkg::data_t a, core_pkg::data_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r = SEED;
    prog[0]  = enc_u(20'h12345, 1, core_pkg::OP_LUI);
    prog[1]  = enc_i(12'h678, 1, 3'b000, 1, core_pkg::OP_IMM); // needs x1 from the lui
    prog[2]  = enc_u(20'h00001, 2, core_pkg::OP_AUIPC);
    prog[3]  = enc_r(7'h00, 2, 1, 3'b000, 3);
    prog[4]  = enc_i(12'h005, 1, 3'b000, 0, core_pkg::OP_IMM); // writes x0
    prog[5]  = enc_r(7'h00, 1, 0, 3'b000, 4);
    prog[6]  = enc_i(12'h007, 0, 3'b000, 5, core_pkg::OP_IMM);
    prog[7]  = enc_r(7'h00, 5, 1, 3'b001, 6); // sll by seven
    prog[8]  = enc_r(7'h00, 6, 6, 3'b000, 7); // waits for the shift
    prog[9]  = enc_i(12'hf9c, 0, 3'b000, 9, core_pkg::OP_IMM);
    prog[10] = enc_i(12'h403, 9, 3'b101, 8, core_pkg::OP_IMM);
    prog[11] = enc_i(12'h01f, 9, 3'b101, 10, core_pkg::OP_IMM);
    prog[12] = enc_b(13'd12, 5, 5, 3'b000);
    prog[13] = enc_i(12'h001, 0, 3'b000, 11, core_pkg::OP_IMM);
    prog[14] = enc_i(12'h002, 0, 3'b000, 11, core_pkg::OP_IMM);
    prog[15] = enc_b(13'd8, 5, 5, 3'b001);
    prog[16] = enc_b(13'd8, 5, 9, 3'b100);
    prog[17] = enc_i(12'h003, 0, 3'b000, 12, core_pkg::OP_IMM);
    prog[18] = enc_b(13'd8, 5, 9, 3'b110);
    prog[19] = enc_b(13'd8, 5, 9, 3'b111);
    prog[20] = enc_i(12'h004, 0, 3'b000, 12, core_pkg::OP_IMM);
    prog[21] = enc_j(21'd8, 13);
    prog[22] = enc_i(12'h005, 0, 3'b000, 12, core_pkg::OP_IMM);
    prog[23] = enc_i(12'd109, 0, 3'b000, 14, core_pkg::OP_IMM);
    prog[24] = enc_i(12'h000, 14, 3'b000, 15, core_pkg::OP_JALR); // odd target, bit 0 dropped
    prog[25] = enc_i(12'h006, 0, 3'b000, 12, core_pkg::OP_IMM);
    prog[26] = enc_i(12'h007, 0, 3'b000, 12, core_pkg::OP_IMM);
    prog[27] = enc_r(7'h20, 13, 15, 3'b000, 12);
    prog[28] = enc_i(12'h000, 9, 3'b010, 11, core_pkg::OP_IMM);
    prog[29] = enc_r(7'h00, 9, 0, 3'b011, 11);
    for (int i = N_FIXED; i < PROG_LEN; i++) begin
      r   = xorshift(r);
      f3  = r[2:0];
      imm = r[26:15];
      if (r[27]) begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[28]) ? 7'h20 : 7'h00;
        prog[i] = enc_r(f7, r[14:11], r[10:7], f3, r[6:3]);
      end else begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {1'b0, (f3 == 3'b101) && r[28], 5'b0, r[19:15]}; // shifts keep funct7 legal
        end
        prog[i] = enc_i(imm, r[10:7], f3, r[6:3], core_pkg::OP_IMM);
      end
    end
  endtask

  // runs the program in order and records every writeback and redirect it expects
  task automatic run_reference();
    core_pkg::data_t    regs [16];
    core_pkg::data_t    pc;
    core_pkg::data_t    next;
    core_pkg::data_t    res;
    core_pkg::data_t    a;
    core_pkg::data_t    b;
    core_pkg::data_t    imm_i;
    core_pkg::inst_t    inst;
    logic [6:0]         opc;
    logic [2:0]         f3;
    core_pkg::reg_idx_t rd;
    logic               wr;
    logic               jump;
    int                 steps;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    pc    = '0;
    steps = 0;
    while (int'(pc >> 2) < PROG_LEN && steps < MEM_DEPTH) begin
      inst  = prog[pc[8:2]];
      opc   = inst[6:0];
      f3    = inst[14:12];
      rd    = inst[10:7];
      a     = regs[inst[18:15]];
      b     = regs[inst[23:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      next  = pc + 32'd4;
      wr    = 1'b1;
      jump  = 1'b0;
      res   = '0;
      case (opc)
        core_pkg::OP_LUI:   res = {inst[31:12], 12'b0};
        core_pkg::OP_AUIPC: res = pc + {inst[31:12], 12'b0};
        core_pkg::OP_JAL: begin
          res  = pc + 32'd4;
          next = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
          jump = 1'b1;
        end
        core_pkg::OP_JALR: begin
          res  = pc + 32'd4;
          next = (a + imm_i) & ~32'd1;
          jump = 1'b1;
        end
        core_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (branch_taken(f3, a, b)) begin
            next = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            jump = 1'b1;
          end
        end
        core_pkg::OP_IMM: res = alu_ref(f3, inst[30] && (f3 == 3'b101), a, imm_i);
        default:          res = alu_ref(f3, inst[30], a, b);
      endcase
      if (wr && rd != '0) begin
        regs[rd]       = res;
        exp_rd[n_wb]   = rd;
        exp_data[n_wb] = res;
        n_wb++;
      end
      if (jump) begin
        exp_redir[n_redir] = next;
        n_redir++;
      end
      pc = next;
      steps++;
    end
  endtask

  // a redirect replaces whatever was on offer during the flushed cycle
  always @(posedge clk) begin : fetch_model
    logic            rst_seen;
    logic            took;
    logic            redir_seen;
    core_pkg::data_t redir_pc;
    int              idx;
    rst_seen   = rst;
    took       = fetch_valid_i && fetch_ready_o;
    redir_seen = redirect_valid_o;
    redir_pc   = redirect_pc_o;
    #1;
    if (rst_seen) begin
      fpc = '0;
    end else if (redir_seen) begin
      fpc = redir_pc;
    end else if (took) begin
      fpc = fpc + 32'd4;
    end
    idx           = int'(fpc >> 2);
    fetch_valid_i = !rst_seen && (idx < PROG_LEN);
    fetch_inst_i  = prog[idx[6:0]];
    fetch_pc_i    = fpc;
  end

  always @(posedge clk) begin
    if (rst) begin
      wb_idx    <= 0;
      redir_idx <= 0;
    end else begin
      if (wb_valid_o) wb_idx <= wb_idx + 1;
      if (redirect_valid_o) redir_idx <= redir_idx + 1;
    end
  end

  assign exp_rd_now    = exp_rd[wb_idx[6:0]];
  assign exp_data_now  = exp_data[wb_idx[6:0]];
  assign exp_redir_now = exp_redir[redir_idx[6:0]];

  a_reset_state : assert property (@(posedge clk)
    $fell(rst) |-> fetch_ready_o && !wb_valid_o && !redirect_valid_o)
    else begin
      proto_err++;
      $display("core not idle right after reset");
    end

  a_wb_rd : assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> wb_rd_o == exp_rd_now)
    else begin
      wb_err++;
      $display("Fail wb_rd[%0d] expected %0d actual %0d", $sampled(wb_idx),
               $sampled(exp_rd_now), $sampled(wb_rd_o));
    end

  a_wb_data : assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> wb_data_o == exp_data_now)
    else begin
      wb_err++;
      $display("Fail wb_data[%0d] expected %h actual %h", $sampled(wb_idx),
               $sampled(exp_data_now), $sampled(wb_data_o));
    end

  a_wb_extra : assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> wb_idx < n_wb)
    else begin
      wb_err++;
      $display("writeback seen after the last expected one");
    end

  a_no_x0_write : assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> wb_rd_o != '0)
    else begin
      wb_err++;
      $display("writeback to x0 showed up on the writeback port");
    end

  a_redirect_pc : assert property (@(posedge clk) disable iff (rst)
    redirect_valid_o |-> redir_idx < n_redir && redirect_pc_o == exp_redir_now)
    else begin
      redir_err++;
      $display("Fail redirect_pc[%0d] expected %h actual %h", $sampled(redir_idx),
               $sampled(exp_redir_now), $sampled(redirect_pc_o));
    end

  a_shift_hold : assert property (@(posedge clk) disable iff (rst)
    uut.u_exec.state_q == core_pkg::EX_SHIFT && uut.u_decode.valid_q |-> !fetch_ready_o)
    else begin
      proto_err++;
      $display("fetch accepted while decode was held behind a running shift");
    end

  initial begin
    build_program();
    run_reference();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    while (wb_idx < n_wb || redir_idx < n_redir || fetch_valid_i) @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk); // room for a stray late writeback
    if (wb_idx != n_wb || redir_idx != n_redir) begin
      proto_err++;
      $display("writeback or redirect count differs from the reference program");
    end
    $display("errors: writeback %0d, redirect %0d, protocol %0d", wb_err, redir_err,
             proto_err);
    if (wb_err + redir_err + proto_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the program did not drain in %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: logic/busy_table.sv
`timescale 1ns/1ns

module busy_table (
  input  logic                clk,
  input  logic                rst,
  input  logic                set_i,
  input  core_pkg::reg_idx_t  set_rd_i,
  input  logic                clr_i,
  input  core_pkg::reg_idx_t  clr_rd_i,
  output core_pkg::reg_mask_t busy_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o <= '0;
    end else begin
      if (clr_i) begin
        busy_o[clr_rd_i] <= 1'b0;
      end
      // placed after the clear so a new writer of the same register wins
      if (set_i && (set_rd_i != '0)) begin
        busy_o[set_rd_i] <= 1'b1;
      end
    end
  end

  a_clr_pending : assert property (@(posedge clk) disable iff (rst)
    clr_i |-> busy_o[clr_rd_i])
    else $error("writeback to a register with no pending write");

endmodule

// File: logic/core_pkg.sv
package core_pkg;

  localparam int XLEN    = 32;
  localparam int ILEN    = 32;
  localparam int NREGS   = 16;
  localparam int REG_W   = 4;
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0]    data_t;
  typedef logic [ILEN-1:0]    inst_t;
  typedef logic [REG_W-1:0]   reg_idx_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [NREGS-1:0]   reg_mask_t; // one bit per architectural register

  // major opcodes of the supported subset
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } br_kind_e;

  typedef enum logic {
    EX_IDLE,
    EX_SHIFT
  } exec_state_e;

endpackage

// File: logic/decode_core.sv
`timescale 1ns/1ns

module decode_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_valid_i,
  input  core_pkg::inst_t    fetch_inst_i,
  input  core_pkg::data_t    fetch_pc_i,
  output logic               fetch_ready_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::data_t    wb_data_o,
  output logic               redirect_valid_o,
  output core_pkg::data_t    redirect_pc_o
);

  core_pkg::reg_idx_t  rs1;
  core_pkg::reg_idx_t  rs2;
  core_pkg::data_t     rdata1;
  core_pkg::data_t     rdata2;
  core_pkg::reg_mask_t busy;
  logic                exec_ready;
  logic                issue;
  core_pkg::reg_idx_t  iss_rd;
  logic                iss_wen;
  core_pkg::data_t     iss_op1;
  core_pkg::data_t     iss_op2;
  core_pkg::alu_op_e   iss_alu_op;
  core_pkg::br_kind_e  iss_br;
  core_pkg::data_t     iss_cmp_a;
  core_pkg::data_t     iss_cmp_b;
  core_pkg::data_t     iss_target;
  core_pkg::data_t     iss_link;

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_inst_i  (fetch_inst_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_ready_o (fetch_ready_o),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .busy_i        (busy),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .flush_i       (redirect_valid_o),
    .exec_ready_i  (exec_ready),
    .issue_o       (issue),
    .iss_rd_o      (iss_rd),
    .iss_wen_o     (iss_wen),
    .iss_op1_o     (iss_op1),
    .iss_op2_o     (iss_op2),
    .iss_alu_op_o  (iss_alu_op),
    .iss_br_o      (iss_br),
    .iss_cmp_a_o   (iss_cmp_a),
    .iss_cmp_b_o   (iss_cmp_b),
    .iss_target_o  (iss_target),
    .iss_link_o    (iss_link)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .ra1_i    (rs1),
    .ra2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_valid_o),
    .wa_i     (wb_rd_o),
    .wdata_i  (wb_data_o)
  );

  // iss_rd is zero for instructions that write nothing, so issue alone can set
  busy_table u_busy (
    .clk      (clk),
    .rst      (rst),
    .set_i    (issue),
    .set_rd_i (iss_rd),
    .clr_i    (wb_valid_o),
    .clr_rd_i (wb_rd_o),
    .busy_o   (busy)
  );

  exec_stage u_exec (
    .clk              (clk),
    .rst              (rst),
    .issue_i          (issue),
    .rd_i             (iss_rd),
    .wen_i            (iss_wen),
    .op1_i            (iss_op1),
    .op2_i            (iss_op2),
    .alu_op_i         (iss_alu_op),
    .br_i             (iss_br),
    .cmp_a_i          (iss_cmp_a),
    .cmp_b_i          (iss_cmp_b),
    .target_i         (iss_target),
    .link_i           (iss_link),
    .ready_o          (exec_ready),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_valid_i,
  input  core_pkg::inst_t    fetch_inst_i,
  input  core_pkg::data_t    fetch_pc_i,
  output logic               fetch_ready_o,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  input  core_pkg::data_t    rdata1_i,
  input  core_pkg::data_t    rdata2_i,
  input  core_pkg::reg_mask_t busy_i,
  input  logic               wb_valid_i,
  input  core_pkg::reg_idx_t wb_rd_i,
  input  core_pkg::data_t    wb_data_i,
  input  logic               flush_i,
  input  logic               exec_ready_i,
  output logic               issue_o,
  output core_pkg::reg_idx_t iss_rd_o,
  output logic               iss_wen_o,
  output core_pkg::data_t    iss_op1_o,
  output core_pkg::data_t    iss_op2_o,
  output core_pkg::alu_op_e  iss_alu_op_o,
  output core_pkg::br_kind_e iss_br_o,
  output core_pkg::data_t    iss_cmp_a_o,
  output core_pkg::data_t    iss_cmp_b_o,
  output core_pkg::data_t    iss_target_o,
  output core_pkg::data_t    iss_link_o
);

  logic            valid_q;
  core_pkg::inst_t inst_q;
  core_pkg::data_t pc_q;
  core_pkg::data_t src1;
  core_pkg::data_t src2;
  logic            fwd1;
  logic            fwd2;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            hazard;
  logic            take;
  logic            legal;

  assign rs1_o = inst_q[18:15];
  assign rs2_o = inst_q[23:20];

  // the writeback register is written on this edge, so its value comes from the bypass
  assign fwd1 = wb_valid_i && (wb_rd_i == rs1_o);
  assign fwd2 = wb_valid_i && (wb_rd_i == rs2_o);
  assign src1 = fwd1 ? wb_data_i : rdata1_i;
  assign src2 = fwd2 ? wb_data_i : rdata2_i;

  assign hazard = valid_q && ((uses_rs1 && busy_i[rs1_o] && !fwd1) ||
                              (uses_rs2 && busy_i[rs2_o] && !fwd2));

  assign issue_o       = valid_q && !hazard && exec_ready_i && !flush_i;
  assign fetch_ready_o = !flush_i && (!valid_q || issue_o);
  assign take          = fetch_valid_i && fetch_ready_o;

  assign legal = inst_q[6:0] inside {core_pkg::OP_LUI, core_pkg::OP_AUIPC, core_pkg::OP_JAL,
                                     core_pkg::OP_JALR, core_pkg::OP_BRANCH, core_pkg::OP_IMM,
                                     core_pkg::OP_REG};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (issue_o || flush_i) begin
      valid_q <= 1'b0; // a redirect kills the wrong-path instruction
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      inst_q <= fetch_inst_i;
      pc_q   <= fetch_pc_i;
    end
  end

  inst_decoder u_dec (
    .inst_i     (inst_q),
    .pc_i       (pc_q),
    .rs1v_i     (src1),
    .rs2v_i     (src2),
    .rd_o       (iss_rd_o),
    .wen_o      (iss_wen_o),
    .uses_rs1_o (uses_rs1),
    .uses_rs2_o (uses_rs2),
    .op1_o      (iss_op1_o),
    .op2_o      (iss_op2_o),
    .alu_op_o   (iss_alu_op_o),
    .br_o       (iss_br_o),
    .cmp_a_o    (iss_cmp_a_o),
    .cmp_b_o    (iss_cmp_b_o),
    .target_o   (iss_target_o),
    .link_o     (iss_link_o)
  );

  a_flush_kill : assert property (@(posedge clk) disable iff (rst)
    flush_i |=> !valid_q)
    else $error("instruction in decode survived a redirect");

  a_stall_hold : assert property (@(posedge clk) disable iff (rst)
    valid_q && !issue_o && !flush_i |=> valid_q && $stable(inst_q) && $stable(pc_q))
    else $error("stalled instruction changed before issue");

  a_legal_op : assert property (@(posedge clk) disable iff (rst)
    valid_q |-> legal)
    else $error("unsupported opcode in decode");

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               wen_i,
  input  core_pkg::data_t    op1_i,
  input  core_pkg::data_t    op2_i,
  input  core_pkg::alu_op_e  alu_op_i,
  input  core_pkg::br_kind_e br_i,
  input  core_pkg::data_t    cmp_a_i,
  input  core_pkg::data_t    cmp_b_i,
  input  core_pkg::data_t    target_i,
  input  core_pkg::data_t    link_i,
  output logic               ready_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::data_t    wb_data_o,
  output logic               redirect_valid_o,
  output core_pkg::data_t    redirect_pc_o
);

  core_pkg::exec_state_e state_q;
  core_pkg::data_t       acc_q;
  core_pkg::shamt_t      cnt_q;
  core_pkg::alu_op_e     shift_op_q;
  logic                  wen_q;
  core_pkg::shamt_t      shamt;
  core_pkg::data_t       alu_res;
  core_pkg::data_t       shifted;
  logic                  is_shift;
  logic                  is_jump;
  logic                  taken;

  assign shamt    = op2_i[core_pkg::SHAMT_W-1:0];
  assign is_shift = alu_op_i inside {core_pkg::ALU_SLL, core_pkg::ALU_SRL, core_pkg::ALU_SRA};
  assign is_jump  = (br_i == core_pkg::BR_JAL) || (br_i == core_pkg::BR_JALR);
  assign ready_o  = (state_q == core_pkg::EX_IDLE);

  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_SUB:    alu_res = op1_i - op2_i;
      core_pkg::ALU_SLT:    alu_res = core_pkg::data_t'($signed(op1_i) < $signed(op2_i));
      core_pkg::ALU_SLTU:   alu_res = core_pkg::data_t'(op1_i < op2_i);
      core_pkg::ALU_XOR:    alu_res = op1_i ^ op2_i;
      core_pkg::ALU_OR:     alu_res = op1_i | op2_i;
      core_pkg::ALU_AND:    alu_res = op1_i & op2_i;
      core_pkg::ALU_PASS_B: alu_res = op2_i;
      core_pkg::ALU_SLL, core_pkg::ALU_SRL, core_pkg::ALU_SRA:
        alu_res = op1_i; // only reached for a zero shift amount
      default:              alu_res = op1_i + op2_i;
    endcase
  end

  always_comb begin
    case (shift_op_q)
      core_pkg::ALU_SLL: shifted = {acc_q[core_pkg::XLEN-2:0], 1'b0};
      core_pkg::ALU_SRA: shifted = {acc_q[core_pkg::XLEN-1], acc_q[core_pkg::XLEN-1:1]};
      default:           shifted = {1'b0, acc_q[core_pkg::XLEN-1:1]};
    endcase
  end

  always_comb begin
    case (br_i)
      core_pkg::BR_JAL, core_pkg::BR_JALR: taken = 1'b1;
      core_pkg::BR_BEQ:  taken = (cmp_a_i == cmp_b_i);
      core_pkg::BR_BNE:  taken = (cmp_a_i != cmp_b_i);
      core_pkg::BR_BLT:  taken = $signed(cmp_a_i) < $signed(cmp_b_i);
      core_pkg::BR_BGE:  taken = $signed(cmp_a_i) >= $signed(cmp_b_i);
      core_pkg::BR_BLTU: taken = cmp_a_i < cmp_b_i;
      core_pkg::BR_BGEU: taken = cmp_a_i >= cmp_b_i;
      default:           taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= core_pkg::EX_IDLE;
      wb_valid_o       <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      wb_valid_o       <= 1'b0;
      redirect_valid_o <= 1'b0;
      case (state_q)
        core_pkg::EX_IDLE: begin
          if (issue_i) begin
            redirect_valid_o <= taken;
            if (is_shift && (shamt != '0)) begin
              state_q <= core_pkg::EX_SHIFT;
            end else begin
              wb_valid_o <= wen_i;
            end
          end
        end
        default: begin
          if (cnt_q == core_pkg::shamt_t'(1)) begin // last bit goes out with the result
            state_q    <= core_pkg::EX_IDLE;
            wb_valid_o <= wen_q;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == core_pkg::EX_IDLE && issue_i) begin
      wb_rd_o       <= rd_i;
      wb_data_o     <= is_jump ? link_i : alu_res;
      redirect_pc_o <= target_i;
      acc_q         <= op1_i;
      cnt_q         <= shamt;
      shift_op_q    <= alu_op_i;
      wen_q         <= wen_i;
    end else if (state_q == core_pkg::EX_SHIFT) begin
      acc_q     <= shifted;
      cnt_q     <= cnt_q - core_pkg::shamt_t'(1);
      wb_data_o <= shifted;
    end
  end

  a_issue_ready : assert property (@(posedge clk) disable iff (rst)
    issue_i |-> ready_o)
    else $error("issue while a shift is still running");

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
  input  core_pkg::inst_t    inst_i,
  input  core_pkg::data_t    pc_i,
  input  core_pkg::data_t    rs1v_i,
  input  core_pkg::data_t    rs2v_i,
  output core_pkg::reg_idx_t rd_o,
  output logic               wen_o,
  output logic               uses_rs1_o,
  output logic               uses_rs2_o,
  output core_pkg::data_t    op1_o,
  output core_pkg::data_t    op2_o,
  output core_pkg::alu_op_e  alu_op_o,
  output core_pkg::br_kind_e br_o,
  output core_pkg::data_t    cmp_a_o,
  output core_pkg::data_t    cmp_b_o,
  output core_pkg::data_t    target_o,
  output core_pkg::data_t    link_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               alt;
  logic               writes;
  core_pkg::reg_idx_t rd;
  core_pkg::data_t    imm_i;
  core_pkg::data_t    imm_u;
  core_pkg::data_t    imm_j;
  core_pkg::data_t    imm_b;
  core_pkg::data_t    jalr_sum;
  core_pkg::alu_op_e  arith_op;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign alt    = inst_i[30]; // selects sub and sra
  assign rd     = inst_i[10:7]; // rv32e only has 16 registers

  assign imm_i = {{(core_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{(core_pkg::XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
  assign imm_b = {{(core_pkg::XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == core_pkg::OP_REG && alt) ? core_pkg::ALU_SUB
                                                               : core_pkg::ALU_ADD;
      3'b001:  arith_op = core_pkg::ALU_SLL;
      3'b010:  arith_op = core_pkg::ALU_SLT;
      3'b011:  arith_op = core_pkg::ALU_SLTU;
      3'b100:  arith_op = core_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  arith_op = core_pkg::ALU_OR;
      default: arith_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    writes     = 1'b0;
    uses_rs1_o = 1'b0;
    uses_rs2_o = 1'b0;
    op1_o      = '0;
    op2_o      = '0;
    alu_op_o   = core_pkg::ALU_ADD;
    br_o       = core_pkg::BR_NONE;
    case (opcode)
      core_pkg::OP_LUI: begin
        writes   = 1'b1;
        op2_o    = imm_u;
        alu_op_o = core_pkg::ALU_PASS_B;
      end
      core_pkg::OP_AUIPC: begin
        writes = 1'b1;
        op1_o  = pc_i;
        op2_o  = imm_u;
      end
      core_pkg::OP_JAL: begin
        writes = 1'b1;
        br_o   = core_pkg::BR_JAL;
      end
      core_pkg::OP_JALR: begin
        writes     = 1'b1;
        uses_rs1_o = 1'b1;
        br_o       = core_pkg::BR_JALR;
      end
      core_pkg::OP_BRANCH: begin
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        case (funct3)
          3'b000:  br_o = core_pkg::BR_BEQ;
          3'b001:  br_o = core_pkg::BR_BNE;
          3'b100:  br_o = core_pkg::BR_BLT;
          3'b101:  br_o = core_pkg::BR_BGE;
          3'b110:  br_o = core_pkg::BR_BLTU;
          3'b111:  br_o = core_pkg::BR_BGEU;
          default: br_o = core_pkg::BR_NONE;
        endcase
      end
      core_pkg::OP_IMM: begin
        writes     = 1'b1;
        uses_rs1_o = 1'b1;
        op1_o      = rs1v_i;
        op2_o      = imm_i; // shift amount sits in the low five bits
        alu_op_o   = arith_op;
      end
      core_pkg::OP_REG: begin
        writes     = 1'b1;
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        op1_o      = rs1v_i;
        op2_o      = rs2v_i;
        alu_op_o   = arith_op;
      end
      default: ;
    endcase
  end

  assign wen_o    = writes && (rd != '0);
  assign rd_o     = wen_o ? rd : '0; // x0 as rd means nothing gets marked busy
  assign cmp_a_o  = rs1v_i;
  assign cmp_b_o  = rs2v_i;
  assign link_o   = pc_i + core_pkg::data_t'(4);
  assign jalr_sum = rs1v_i + imm_i;
  assign target_o = (opcode == core_pkg::OP_JALR) ? {jalr_sum[core_pkg::XLEN-1:1], 1'b0}
                  : pc_i + ((opcode == core_pkg::OP_JAL) ? imm_j : imm_b);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t ra1_i,
  input  core_pkg::reg_idx_t ra2_i,
  output core_pkg::data_t    rdata1_o,
  output core_pkg::data_t    rdata2_o,
  input  logic               we_i,
  input  core_pkg::reg_idx_t wa_i,
  input  core_pkg::data_t    wdata_i
);

  core_pkg::data_t regs [core_pkg::NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa_i != '0)) begin
      regs[wa_i] <= wdata_i;
    end
  end

  // x0 reads as zero no matter what
  assign rdata1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
  assign rdata2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

// File: src.f
logic/core_pkg.sv
logic/inst_decoder.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/busy_table.sv
logic/exec_stage.sv
logic/decode_core.sv
bench/decode_core_tb.sv
